//--- build.f
hdl/bridge_pkg.sv
hdl/bridge_ifs.sv
hdl/rx_frame_assembler.sv
hdl/bridge_sequencer.sv
hdl/apb_master.sv
hdl/resp_sender.sv
hdl/cmd_bridge_top.sv
tests/tb_clock_gen.sv
tests/tb_cmd_bridge.sv

//--- Makefile
# Verilator build for the UART command bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_cmd_bridge
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_cmd_bridge.sv
`default_nettype none

module tb_cmd_bridge;
  timeunit 1ns;
  timeprecision 1ps;
  import bridge_pkg::*;

  localparam addr_t ERR_BASE      = 8'hF0;  // Slave flags pslverr from here up
  localparam int    READY_TIMEOUT = 1000;
  localparam int    DRAIN_TIMEOUT = 4000;

  logic    clk;
  logic    rst_n;
  logic    rx_valid;
  byte_t   rx_data;
  rx_err_t rx_err;
  logic    cmd_ready;
  logic    tx_valid;
  byte_t   tx_data;
  logic    tx_credit = 1'b0;
  logic    psel;
  logic    penable;
  logic    pwrite;
  addr_t   paddr;
  data_t   pwdata;
  data_t   prdata = '0;
  logic    pready = 1'b0;
  logic    pslverr = 1'b0;

  integer  seed = 32'he100fb76;
  integer  apb_seed = 32'he100fb76 ^ 32'h0000_00a5;
  integer  crd_seed = 32'he100fb76 ^ 32'h0000_5a00;

  byte_t   exp_q [$];       // Predicted response bytes in send order
  byte_t   exp_b;
  data_t   ref_mem [0:255];
  data_t   slave_mem [0:255];
  addr_t   addrs [0:7];
  logic [31:0] main_rnd;
  int      errors = 0;
  int      errs_before = 0;
  int      n_tests = 0;
  int      n_failed = 0;
  logic    timed_out = 1'b0;
  logic    credit_hold = 1'b0;
  int      outstanding = 0;   // Bytes the transmitter still has to credit back
  int      owed = 0;          // Bytes not yet answered by the credit returner
  logic [31:0] rnd_crd;

  // APB slave model state
  logic        nxt_pready = 1'b0;
  data_t       nxt_prdata = '0;
  logic        nxt_pslverr = 1'b0;
  logic [31:0] rnd_apb;
  logic [1:0]  wait_left;
  logic        phase_open = 1'b0;
  addr_t       setup_addr;
  int          apb_count = 0;
  int          apb_expected = 0;
  int          apb_errs = 0;

  tb_clock_gen u_clk (.clk(clk));

  cmd_bridge_top uut (.*);

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic data_t fill_word(input addr_t a);
    return {a, ~a, a ^ 8'h5A, a + 8'hC3};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic wait_cmd_ready();
    int n;
    n = 0;
    while (!timed_out) begin
      @(negedge clk);
      if (cmd_ready)
        break;
      n++;
      if (n > READY_TIMEOUT) begin
        $display("Timeout at %0t: cmd_ready stayed low too long", $time);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (!timed_out && exp_q.size() != 0) begin
      @(posedge clk);
      n++;
      if (n > DRAIN_TIMEOUT) begin
        $display("Timeout at %0t: %0d response bytes never arrived", $time, exp_q.size());
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic send_byte(input byte_t b);
    logic [31:0] r;
    r = next_rand();
    if (r[2:0] == 3'd0) begin  // Occasional idle gap
      @(posedge clk);
      rx_valid <= 1'b0;
    end
    @(posedge clk);
    rx_valid <= 1'b1;
    rx_data  <= b;
  endtask

  task automatic end_bytes();
    @(posedge clk);
    rx_valid <= 1'b0;
    rx_data  <= '0;
  endtask

  task automatic write_reg(input addr_t a, input data_t d);
    logic [31:0] r;
    r = next_rand();
    wait_cmd_ready();
    if (timed_out)
      return;
    send_byte({r[7:4], 4'h2});
    send_byte(a);
    for (int i = 3; i >= 0; i--)
      send_byte(d[i*8 +: 8]);  // MSB first
    end_bytes();
    exp_q.push_back(8'h05);
    exp_q.push_back(a);
    exp_q.push_back((a >= ERR_BASE) ? 8'h01 : 8'h00);
    if (a < ERR_BASE)
      ref_mem[a] = d;
    apb_expected++;
  endtask

  task automatic read_reg(input addr_t a);
    logic [31:0] r;
    data_t       d;
    r = next_rand();
    wait_cmd_ready();
    if (timed_out)
      return;
    send_byte({r[7:4], 4'h1});
    send_byte(a);
    end_bytes();
    d = (a >= ERR_BASE) ? '0 : ref_mem[a];
    for (int i = 3; i >= 0; i--)
      exp_q.push_back(d[i*8 +: 8]);
    apb_expected++;
  endtask

  task automatic send_bad_opcode();
    logic [31:0] r;
    r = next_rand();
    if (r[3:0] == 4'h1 || r[3:0] == 4'h2)
      r[3:0] = r[3:0] + 4'h4;
    wait_cmd_ready();
    if (timed_out)
      return;
    @(posedge clk);
    rx_err <= 2'b11;  // Stray error in idle, must be dropped
    @(posedge clk);
    rx_err <= 2'b00;
    send_byte(r[7:0]);
    end_bytes();
    exp_q.push_back(8'h0F);
    exp_q.push_back(8'h01);
  endtask

  task automatic send_rx_error(input logic is_write, input rx_err_t e);
    logic [31:0] r;
    int          n_ops;
    r = next_rand();
    n_ops = is_write ? int'(r[31:16] % 5) : 0;
    wait_cmd_ready();
    if (timed_out)
      return;
    send_byte({r[7:4], is_write ? 4'h2 : 4'h1});
    for (int i = 0; i < n_ops; i++)
      send_byte(byte_t'(next_rand()));
    @(posedge clk);
    rx_valid <= r[8];  // Error may come with or without a byte
    rx_data  <= r[15:8];
    rx_err   <= e;
    @(posedge clk);
    rx_valid <= 1'b0;
    rx_err   <= 2'b00;
    exp_q.push_back(8'h0F);
    exp_q.push_back({5'b0, e, 1'b0});
  endtask

  task automatic begin_test();
    errs_before = errors;
  endtask

  task automatic end_test(input string name);
    wait_drain();
    if (!timed_out && apb_count != apb_expected)
      report_failure($sformatf("%0d APB transfers seen, %0d expected",
                               apb_count, apb_expected));
    n_tests++;
    if (errors == errs_before && !timed_out) begin
      $display("%-30s passed", name);
    end else begin
      n_failed++;
      $display("%-30s failed", name);
    end
  endtask

  // Response checker and credit bookkeeping
  always @(negedge clk) begin
    if (rst_n) begin
      if (tx_valid) begin
        if (outstanding >= TX_CREDITS)
          report_failure("byte sent while no transmit credit was left");
        outstanding++;
        owed++;
        if (exp_q.size() == 0) begin
          report_failure($sformatf("unexpected response byte %02h", tx_data));
        end else begin
          exp_b = exp_q.pop_front();
          check_value("tx_data", tx_data, exp_b);
        end
      end
      if (tx_credit)
        outstanding--;
    end
  end

  // Credit returner, slower while credits are held back
  always @(posedge clk) begin
    tx_credit <= 1'b0;
    if (rst_n && owed > 0) begin
      rnd_crd = $random(crd_seed);
      if (credit_hold ? (rnd_crd[2:0] == 3'd0) : rnd_crd[0]) begin
        tx_credit <= 1'b1;
        owed--;
      end
    end
  end

  // APB slave, decisions at negedge and outputs on the next rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      nxt_pready = 1'b0;
      phase_open = 1'b0;
    end else if (psel && !penable) begin
      phase_open  = 1'b1;
      setup_addr  = paddr;
      apb_count++;
      rnd_apb     = $random(apb_seed);
      wait_left   = rnd_apb[1:0];
      nxt_pready  = (wait_left == 2'd0);
      nxt_prdata  = (paddr >= ERR_BASE) ? '0 : slave_mem[paddr];
      nxt_pslverr = (paddr >= ERR_BASE);
    end else if (penable) begin
      if (!psel || !phase_open) begin
        report_failure("penable high without a setup phase");
        apb_errs++;
      end
      if (paddr !== setup_addr) begin
        check_value("paddr", paddr, setup_addr);
        apb_errs++;
      end
      if (pready) begin  // Transfer completes on the coming edge
        if (pwrite && paddr < ERR_BASE)
          slave_mem[paddr] = pwdata;
        phase_open  = 1'b0;
        nxt_pready  = 1'b0;
        nxt_pslverr = 1'b0;
      end else begin
        wait_left  = wait_left - 2'd1;
        nxt_pready = (wait_left == 2'd0);
      end
    end else begin
      if (phase_open) begin
        report_failure("psel dropped before pready");
        apb_errs++;
        phase_open = 1'b0;
      end
      nxt_pready = 1'b0;
    end
  end

  always @(posedge clk) begin
    pready  <= nxt_pready;
    prdata  <= nxt_prdata;
    pslverr <= nxt_pslverr;
  end

  initial begin
    rst_n    = 1'b0;
    rx_valid = 1'b0;
    rx_data  = '0;
    rx_err   = 2'b00;
    for (int i = 0; i < 256; i++) begin
      slave_mem[i] = fill_word(addr_t'(i));
      ref_mem[i]   = fill_word(addr_t'(i));
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    begin_test();
    @(negedge clk);
    check_value("cmd_ready", cmd_ready, 1);
    check_value("tx_valid", tx_valid, 0);
    check_value("psel", psel, 0);
    check_value("penable", penable, 0);
    end_test("reset values");

    begin_test();
    for (int i = 0; i < 8; i++) begin
      addrs[i] = addr_t'(next_rand() % 32'd240);
      write_reg(addrs[i], next_rand());
    end
    for (int i = 0; i < 8; i++)
      read_reg(addrs[i]);
    end_test("write then read back");

    begin_test();
    for (int i = 0; i < 4; i++) begin
      main_rnd = next_rand();
      write_reg(ERR_BASE + addr_t'(main_rnd[3:0]), next_rand());
      read_reg(ERR_BASE + addr_t'(main_rnd[3:0]));
    end
    end_test("slave error range");

    begin_test();
    for (int i = 0; i < 6; i++) begin
      main_rnd = next_rand();
      send_bad_opcode();
      send_rx_error(main_rnd[0], (main_rnd[2:1] == 2'b00) ? 2'b01 : main_rnd[2:1]);
    end
    end_test("bad opcode and rx errors");

    begin_test();
    credit_hold = 1'b1;
    for (int i = 0; i < 40; i++) begin
      main_rnd = next_rand();
      case (main_rnd[1:0])
        2'd0: write_reg(main_rnd[15:8], next_rand());
        2'd1: read_reg(main_rnd[15:8]);
        2'd2: begin
          if (main_rnd[4])
            send_bad_opcode();
          else
            send_rx_error(main_rnd[5], (main_rnd[7:6] == 2'b00) ? 2'b10 : main_rnd[7:6]);
        end
        default: read_reg(addrs[main_rnd[10:8]]);
      endcase
    end
    end_test("mixed stream, credits held");
    credit_hold = 1'b0;

    begin_test();
    if (apb_errs != 0)
      report_failure($sformatf("%0d APB protocol errors during the run", apb_errs));
    if (apb_count == 0)
      report_failure("no APB transfer was seen");
    end_test("APB setup and access phases");

    $display("Summary: %0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
    if (errors == 0 && n_failed == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 20;  // 40 ns period

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- hdl/cmd_bridge_top.sv
`default_nettype none

module cmd_bridge_top (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // UART receive side
  input  wire logic                rx_valid,
  input  wire bridge_pkg::byte_t   rx_data,
  input  wire bridge_pkg::rx_err_t rx_err,
  output logic                     cmd_ready,
  // UART transmit side
  output logic                     tx_valid,
  output bridge_pkg::byte_t        tx_data,
  input  wire logic                tx_credit,
  // APB
  output logic                     psel,
  output logic                     penable,
  output logic                     pwrite,
  output bridge_pkg::addr_t        paddr,
  output bridge_pkg::data_t        pwdata,
  input  wire bridge_pkg::data_t   prdata,
  input  wire logic                pready,
  input  wire logic                pslverr
);

  frame_if   frame_ch ();
  bus_req_if bus_ch ();
  resp_if    resp_ch ();

  rx_frame_assembler u_assembler (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_err    (rx_err),
    .cmd_ready (cmd_ready),
    .frame     (frame_ch.src)
  );

  bridge_sequencer u_sequencer (
    .clk   (clk),
    .rst_n (rst_n),
    .frame (frame_ch.snk),
    .bus   (bus_ch.requester),
    .resp  (resp_ch.src)
  );

  apb_master u_apb (
    .clk     (clk),
    .rst_n   (rst_n),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .bus     (bus_ch.responder)
  );

  resp_sender u_sender (
    .clk       (clk),
    .rst_n     (rst_n),
    .tx_credit (tx_credit),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .resp      (resp_ch.snk)
  );

endmodule

`default_nettype wire

//--- hdl/resp_sender.sv
`default_nettype none

module resp_sender (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         tx_credit,
  output logic              tx_valid,
  output bridge_pkg::byte_t tx_data,
  resp_if.snk               resp
);
  import bridge_pkg::*;

  typedef enum logic {
    S_IDLE,
    S_SEND
  } state_e;

  typedef logic [$clog2(TX_CREDITS+1)-1:0] credit_t;

  state_e        state;
  credit_t       credits;
  resp_idx_t     idx;
  resp_idx_t     last_r;
  resp_payload_t payload_r;

  assign resp.ready = (state == S_IDLE);
  assign tx_valid   = (state == S_SEND) && (credits != '0);
  assign tx_data    = payload_r[idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (resp.valid) begin
            idx   <= '0;
            state <= S_SEND;
          end
        end
        S_SEND: begin
          if (tx_valid) begin
            idx <= idx + 1'b1;
            if (idx == last_r)
              state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // One credit out per byte, one back per tx_credit pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      credits <= credit_t'(TX_CREDITS);
    else if (tx_valid && !tx_credit)
      credits <= credits - 1'b1;
    else if (!tx_valid && tx_credit)
      credits <= credits + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && resp.valid) begin
      payload_r <= resp.payload;
      last_r    <= resp_idx_t'(resp.len - 1'b1);
    end
  end

  // An empty counter can only stay empty or gain one credit
  a_no_tx_without_credit: assert property (
    @(posedge clk) disable iff (!rst_n) (credits == '0) |=> (credits <= credit_t'(1))
  ) else $error("credit count wrapped below zero");

  // Transmitter returns no more credits than bytes it got
  a_credit_bound: assert property (
    @(posedge clk) disable iff (!rst_n) credits <= credit_t'(TX_CREDITS)
  ) else $error("credit count above TX_CREDITS");

endmodule

`default_nettype wire

//--- hdl/apb_master.sv
`default_nettype none

module apb_master (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire bridge_pkg::data_t prdata,
  input  wire logic              pready,
  input  wire logic              pslverr,
  output logic                   psel,
  output logic                   penable,
  output logic                   pwrite,
  output bridge_pkg::addr_t      paddr,
  output bridge_pkg::data_t      pwdata,
  bus_req_if.responder           bus
);
  import bridge_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_SETUP,
    S_ACCESS
  } state_e;

  state_e state;
  logic   done_r;
  logic   write_r;
  addr_t  addr_r;
  data_t  wdata_r;
  data_t  rdata_r;
  logic   slverr_r;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      done_r  <= 1'b0;
      write_r <= 1'b0;
    end else begin
      done_r <= (state == S_ACCESS) && pready;
      case (state)
        S_IDLE: begin
          if (bus.start) begin
            write_r <= bus.write;
            state   <= S_SETUP;
          end
        end
        S_SETUP:  state <= S_ACCESS;
        S_ACCESS: if (pready) state <= S_IDLE;  // Wait states otherwise
        default:  state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && bus.start) begin
      addr_r  <= bus.addr;
      wdata_r <= bus.wdata;
    end
    if (state == S_ACCESS && pready) begin
      rdata_r  <= prdata;
      slverr_r <= pslverr;
    end
  end

  assign psel    = (state != S_IDLE);
  assign penable = (state == S_ACCESS);
  assign pwrite  = write_r;
  assign paddr   = addr_r;
  assign pwdata  = wdata_r;

  assign bus.done   = done_r;
  assign bus.rdata  = rdata_r;
  assign bus.slverr = slverr_r;

  // Access phase always follows a setup cycle
  a_penable_psel: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(penable) |-> $past(psel && !penable)
  ) else $error("penable without a setup phase");

  // Address held through every wait state
  a_paddr_stable: assert property (
    @(posedge clk) disable iff (!rst_n) (penable && !pready) |=> $stable(paddr)
  ) else $error("paddr changed during access phase");

endmodule

`default_nettype wire

//--- hdl/bridge_sequencer.sv
`default_nettype none

module bridge_sequencer (
  input  wire logic     clk,
  input  wire logic     rst_n,
  frame_if.snk          frame,
  bus_req_if.requester  bus,
  resp_if.src           resp
);
  import bridge_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_BUS,
    S_WAIT_DONE,
    S_RESPOND
  } state_e;

  state_e        state;
  logic          take_frame;
  logic          err_frame;
  logic          write_r;
  addr_t         addr_r;
  data_t         wdata_r;
  resp_payload_t payload_r;
  resp_len_t     len_r;

  assign take_frame = frame.valid && (state == S_IDLE);
  assign err_frame  = frame.bad_op || (|frame.rx_err);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (take_frame)
            state <= err_frame ? S_RESPOND : S_BUS;
        end
        S_BUS:       state <= S_WAIT_DONE;
        S_WAIT_DONE: if (bus.done) state <= S_RESPOND;
        S_RESPOND:   if (resp.ready) state <= S_IDLE;
        default:     state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_frame) begin
      write_r <= (frame.op == OP_REG_WRITE);
      addr_r  <= frame.addr;
      wdata_r <= frame.wdata;
      if (err_frame) begin
        payload_r    <= '0;
        payload_r[0] <= RESP_ERROR_CODE;
        payload_r[1] <= byte_t'({frame.rx_err, frame.bad_op});
        len_r        <= resp_len_t'(2);
      end
    end

    if (state == S_WAIT_DONE && bus.done) begin
      if (write_r) begin
        payload_r    <= '0;
        payload_r[0] <= RESP_WRITE_CODE;
        payload_r[1] <= addr_r;
        payload_r[2] <= byte_t'(bus.slverr);
        len_r        <= resp_len_t'(3);
      end else begin
        for (int i = 0; i < DATA_BYTES; i++)
          payload_r[i] <= bus.rdata[DATA_W-1-i*BYTE_W -: BYTE_W];  // MSB leads
        len_r <= resp_len_t'(DATA_BYTES);
      end
    end
  end

  assign frame.ready  = (state == S_IDLE);

  assign bus.start    = (state == S_BUS);
  assign bus.write    = write_r;
  assign bus.addr     = addr_r;
  assign bus.wdata    = wdata_r;

  assign resp.valid   = (state == S_RESPOND);
  assign resp.len     = len_r;
  assign resp.payload = payload_r;

  // APB master must not report completion for a request never issued
  a_done_in_wait: assert property (
    @(posedge clk) disable iff (!rst_n) bus.done |-> (state == S_WAIT_DONE)
  ) else $error("bus done outside wait_done");

endmodule

`default_nettype wire

//--- hdl/rx_frame_assembler.sv
`default_nettype none

module rx_frame_assembler (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              rx_valid,
  input  wire bridge_pkg::byte_t rx_data,
  input  wire bridge_pkg::rx_err_t rx_err,
  output logic                   cmd_ready,
  frame_if.src                   frame
);
  import bridge_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA,
    S_HOLD
  } state_e;

  state_e  state;
  logic [$clog2(DATA_BYTES)-1:0] byte_cnt;
  logic    op_known;
  logic    bad_op_r;
  rx_err_t rx_err_r;
  opcode_e op_r;
  addr_t   addr_r;
  data_t   wdata_r;

  assign op_known = (rx_data[3:0] == OP_REG_READ) || (rx_data[3:0] == OP_REG_WRITE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      byte_cnt <= '0;
      bad_op_r <= 1'b0;
      rx_err_r <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (rx_valid) begin   // Errors in idle are dropped
            bad_op_r <= !op_known;
            state    <= op_known ? S_ADDR : S_HOLD;
          end
        end
        S_ADDR: begin
          if (|rx_err) begin
            rx_err_r <= rx_err;
            state    <= S_HOLD;
          end else if (rx_valid) begin
            byte_cnt <= '0;
            state    <= (op_r == OP_REG_WRITE) ? S_DATA : S_HOLD;
          end
        end
        S_DATA: begin
          if (|rx_err) begin
            rx_err_r <= rx_err;
            state    <= S_HOLD;
          end else if (rx_valid) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == DATA_BYTES - 1)
              state <= S_HOLD;
          end
        end
        S_HOLD: begin
          if (frame.ready) begin
            bad_op_r <= 1'b0;
            rx_err_r <= '0;
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Operand capture
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      if (state == S_IDLE)
        op_r <= opcode_e'(rx_data[3:0]);
      if (state == S_ADDR && !(|rx_err))
        addr_r <= rx_data;
      if (state == S_DATA && !(|rx_err))
        wdata_r <= {wdata_r[DATA_W-BYTE_W-1:0], rx_data};  // MSB first
    end
  end

  assign cmd_ready    = (state != S_HOLD);
  assign frame.valid  = (state == S_HOLD);
  assign frame.op     = op_r;
  assign frame.addr   = addr_r;
  assign frame.wdata  = wdata_r;
  assign frame.bad_op = bad_op_r;
  assign frame.rx_err = rx_err_r;

  // Byte source has to honour cmd_ready, nothing is buffered here
  a_no_byte_while_held: assert property (
    @(posedge clk) disable iff (!rst_n) (state == S_HOLD) |-> !rx_valid
  ) else $error("rx byte lost while a frame is held");

endmodule

`default_nettype wire

//--- hdl/bridge_ifs.sv
`default_nettype none

// Decoded command frame, assembler to sequencer
interface frame_if;
  import bridge_pkg::*;

  logic    valid;
  logic    ready;
  opcode_e op;
  addr_t   addr;
  data_t   wdata;
  logic    bad_op;   // Unknown opcode
  rx_err_t rx_err;   // Receiver error seen during operands

  modport src (output valid, op, addr, wdata, bad_op, rx_err, input ready);
  modport snk (input valid, op, addr, wdata, bad_op, rx_err, output ready);
endinterface

// Single register access, sequencer to APB master
interface bus_req_if;
  import bridge_pkg::*;

  logic  start;   // One-cycle pulse
  logic  write;
  addr_t addr;
  data_t wdata;
  logic  done;    // One-cycle pulse, rdata and slverr valid with it
  data_t rdata;
  logic  slverr;

  modport requester (output start, write, addr, wdata, input done, rdata, slverr);
  modport responder (input start, write, addr, wdata, output done, rdata, slverr);
endinterface

// Formatted response frame, sequencer to sender
interface resp_if;
  import bridge_pkg::*;

  logic          valid;
  logic          ready;
  resp_len_t     len;       // 1 to RESP_MAX_BYTES
  resp_payload_t payload;

  modport src (output valid, len, payload, input ready);
  modport snk (input valid, len, payload, output ready);
endinterface

`default_nettype wire

//--- hdl/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

  localparam int BYTE_W         = 8;
  localparam int ADDR_W         = 8;
  localparam int DATA_W         = 32;
  localparam int DATA_BYTES     = 4;
  localparam int RESP_MAX_BYTES = 4;
  localparam int TX_CREDITS     = 4;  // Depth of the transmitter buffer

  localparam int RESP_IDX_W = $clog2(RESP_MAX_BYTES);
  localparam int RESP_LEN_W = $clog2(RESP_MAX_BYTES + 1);

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Bit 0 framing, bit 1 overrun
  typedef logic [1:0] rx_err_t;

  // Response frame, byte 0 goes out first
  typedef logic [RESP_MAX_BYTES-1:0][BYTE_W-1:0] resp_payload_t;
  typedef logic [RESP_LEN_W-1:0]                 resp_len_t;
  typedef logic [RESP_IDX_W-1:0]                 resp_idx_t;

  localparam byte_t RESP_WRITE_CODE = 8'h05;
  localparam byte_t RESP_ERROR_CODE = 8'h0F;

  // Low nibble of the first command byte
  typedef enum logic [3:0] {
    OP_REG_READ  = 4'd1,
    OP_REG_WRITE = 4'd2
  } opcode_e;

endpackage

`default_nettype wire
